// ==== list.f ====
+incdir+logic
logic/mult_pkg.sv
logic/pipe_pkg.sv
logic/mult_dsp_if.sv
logic/axi_pipe.sv
logic/mult_datapath.sv
logic/mult.sv
logic/mult_top.sv
sim/tb_clock.sv
sim/mult_checker.sv
sim/mult_tb.sv

// ==== logic/axi_pipe.sv ====
//##########################################################################
// valid/ready pipeline with bubble collapsing, tlast rides along as a bit
// STAGES must equal the width of the stage vector type
//##########################################################################
`timescale 1ns/10ps
`include "mult_config.svh"

module axi_pipe #(
   parameter int STAGES = `MULT_LATENCY
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 i_tvalid,
   output logic                 i_tready,
   input  logic                 i_tlast,
   output logic                 o_tvalid,
   input  logic                 o_tready,
   output logic                 o_tlast,
   output pipe_pkg::stage_vec_t enables,
   output pipe_pkg::stage_vec_t valids
);

   logic [STAGES-1:0] vld;
   logic [STAGES-1:0] en;
   logic [STAGES-1:0] last;
   logic [STAGES:0]   vld_chain;  // source of each stage
   logic [STAGES:0]   last_chain;

   if (STAGES < 1 || STAGES != $bits(pipe_pkg::stage_vec_t)) begin : g_bad_stages
      $error("axi_pipe STAGES does not match the stage vector width");
   end

   // a stage takes its predecessor when empty or when the next one moves
   always_comb begin
      en[STAGES-1] = ~vld[STAGES-1] | o_tready;
      for (int i = STAGES - 2; i >= 0; i--) begin
         en[i] = ~vld[i] | en[i+1];
      end
   end

   assign vld_chain  = {vld, i_tvalid};
   assign last_chain = {last, i_tlast};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         vld <= '0;
      end else begin
         for (int i = 0; i < STAGES; i++) begin
            if (en[i]) begin
               vld[i] <= vld_chain[i];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < STAGES; i++) begin
         if (en[i]) begin
            last[i] <= last_chain[i];
         end
      end
   end

   assign i_tready = en[0] & rst_n;  // held low in reset
   assign o_tvalid = vld[STAGES-1];
   assign o_tlast  = last[STAGES-1];
   assign enables  = en;
   assign valids   = vld;

   a_hold_valid: assert property (@(posedge clk) disable iff (!rst_n)
      o_tvalid && !o_tready |=> o_tvalid);

endmodule

// ==== logic/mult.sv ====
//##########################################################################
// joins the A and B streams into one signed multiply of fixed latency
// A and B are consumed together, the product keeps the full width
//##########################################################################
`timescale 1ns/10ps
`include "mult_config.svh"

module mult (
   input  logic                 clk,
   input  logic                 rst_n,
   input  mult_pkg::operand_a_t a_tdata,
   input  logic                 a_tlast,
   input  logic                 a_tvalid,
   output logic                 a_tready,
   input  mult_pkg::operand_b_t b_tdata,
   input  logic                 b_tlast,   // unused, p_tlast follows a_tlast
   input  logic                 b_tvalid,
   output logic                 b_tready,
   output mult_pkg::product_t   p_tdata,
   output logic                 p_tlast,
   output logic                 p_tvalid,
   input  logic                 p_tready
);

   logic                    in_tvalid;
   logic                    in_tready;
   pipe_pkg::stage_vec_t    enables;
   pipe_pkg::stage_vec_t    valids;
   pipe_pkg::stage_vec_t    stage_ce;
   logic [`MULT_LATENCY:0]  src_valid;

   mult_dsp_if dsp ();

   assign in_tvalid = a_tvalid & b_tvalid;
   assign a_tready  = in_tvalid & in_tready;
   assign b_tready  = in_tvalid & in_tready;

   axi_pipe #(.STAGES(`MULT_LATENCY)) u_pipe (
      .clk      (clk),
      .rst_n    (rst_n),
      .i_tvalid (in_tvalid),
      .i_tready (in_tready),
      .i_tlast  (a_tlast),
      .o_tvalid (p_tvalid),
      .o_tready (p_tready),
      .o_tlast  (p_tlast),
      .enables  (enables),
      .valids   (valids)
   );

   // skip register loads for bubbles
   assign src_valid = {valids, in_tvalid};
   assign stage_ce  = enables & src_valid[`MULT_LATENCY-1:0];

   assign dsp.a   = a_tdata;
   assign dsp.b   = b_tdata;
   assign dsp.en  = dsp.to_reg_en(stage_ce);
   assign p_tdata = dsp.p;

   mult_datapath u_datapath (
      .clk   (clk),
      .rst_n (rst_n),
      .dsp   (dsp.dsp)
   );

   a_ready_match: assert property (@(posedge clk) disable iff (!rst_n)
      a_tready == b_tready);

   a_hold_data: assert property (@(posedge clk) disable iff (!rst_n)
      p_tvalid && !p_tready |=> $stable(p_tdata) && $stable(p_tlast));

endmodule

// ==== logic/mult_config.svh ====
//##########################################################################
// operand widths are bounded by the DSP slice, A up to 25 and B up to 18
// latency selects the register set and must be 1 to 4
//##########################################################################
`ifndef MULT_CONFIG_SVH
`define MULT_CONFIG_SVH

// operand A width, max 25
`define MULT_WIDTH_A 25

// operand B width, max 18
`define MULT_WIDTH_B 18

// full product, never truncated
`define MULT_WIDTH_P (`MULT_WIDTH_A + `MULT_WIDTH_B)

// pipeline stages, 1 to 4
`define MULT_LATENCY 3

`endif

// ==== logic/mult_datapath.sv ====
//##########################################################################
// behavioral model of the DSP register chain, full signed product
// register presence is fixed by the latency, absent ones pass through
//##########################################################################
`timescale 1ns/10ps
`include "mult_config.svh"

module mult_datapath (
   input logic     clk,
   input logic     rst_n,
   mult_dsp_if.dsp dsp
);

   localparam bit A1REG = (`MULT_LATENCY == 4);
   localparam bit A2REG = (`MULT_LATENCY >= 2);
   localparam bit PREG  = (`MULT_LATENCY >= 3);

   mult_pkg::operand_a_t a1;
   mult_pkg::operand_b_t b1;
   mult_pkg::operand_a_t a2;
   mult_pkg::operand_b_t b2;
   mult_pkg::product_t   m_q;

   if (A1REG) begin : g_a1
      always_ff @(posedge clk or negedge rst_n) begin
         if (!rst_n) begin
            a1 <= '0;
            b1 <= '0;
         end else if (dsp.en.ce_a1) begin
            a1 <= dsp.a;
            b1 <= dsp.b;
         end
      end
   end else begin : g_no_a1
      assign a1 = dsp.a;
      assign b1 = dsp.b;
   end

   if (A2REG) begin : g_a2
      always_ff @(posedge clk or negedge rst_n) begin
         if (!rst_n) begin
            a2 <= '0;
            b2 <= '0;
         end else if (dsp.en.ce_a2) begin
            a2 <= a1;
            b2 <= b1;
         end
      end
   end else begin : g_no_a2
      assign a2 = a1;
      assign b2 = b1;
   end

   // M register is always present
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         m_q <= '0;
      end else if (dsp.en.ce_m) begin
         m_q <= mult_pkg::product_t'(a2) * mult_pkg::product_t'(b2);  // sign extended
      end
   end

   if (PREG) begin : g_p
      always_ff @(posedge clk or negedge rst_n) begin
         if (!rst_n) begin
            dsp.p <= '0;
         end else if (dsp.en.ce_p) begin
            dsp.p <= m_q;
         end
      end
   end else begin : g_no_p
      assign dsp.p = m_q;
   end

   a_absent_en: assert property (@(posedge clk) disable iff (!rst_n)
      !((!A1REG && dsp.en.ce_a1) || (!A2REG && dsp.en.ce_a2) || (!PREG && dsp.en.ce_p)));

endmodule

// ==== logic/mult_dsp_if.sv ====
//##########################################################################
// control to datapath link; a register loads on a rising clk with its enable
// the stage map follows the register set chosen by the latency
//##########################################################################
`timescale 1ns/10ps
`include "mult_config.svh"

interface mult_dsp_if;

   mult_pkg::operand_a_t a;
   mult_pkg::operand_b_t b;
   mult_pkg::reg_en_t    en;
   mult_pkg::product_t   p;

   // stage enables to register enables
   function automatic mult_pkg::reg_en_t to_reg_en(input pipe_pkg::stage_vec_t s);
      logic [3:0]         e;
      mult_pkg::reg_en_t  r;
      e = 4'(s);
      case (`MULT_LATENCY)
         4:       r = '{ce_a1: e[0], ce_a2: e[1], ce_m: e[2], ce_p: e[3]};
         3:       r = '{ce_a1: 1'b0, ce_a2: e[0], ce_m: e[1], ce_p: e[2]};
         2:       r = '{ce_a1: 1'b0, ce_a2: e[0], ce_m: e[1], ce_p: 1'b0};
         default: r = '{ce_a1: 1'b0, ce_a2: 1'b0, ce_m: e[0], ce_p: 1'b0};
      endcase
      return r;
   endfunction

   modport ctrl (output a, output b, output en, input p, import to_reg_en);
   modport dsp  (input a, input b, input en, output p);

endinterface

// ==== logic/mult_pkg.sv ====
//##########################################################################
// arithmetic types of the multiplier, all signed two's complement
// widths come from the config header
//##########################################################################
`include "mult_config.svh"

package mult_pkg;

   typedef logic signed [`MULT_WIDTH_A-1:0] operand_a_t;
   typedef logic signed [`MULT_WIDTH_B-1:0] operand_b_t;
   typedef logic signed [`MULT_WIDTH_P-1:0] product_t;

   // one enable per DSP register, A1/B1 and A2/B2 share theirs
   typedef struct packed {
      logic ce_a1;
      logic ce_a2;
      logic ce_m;
      logic ce_p;
   } reg_en_t;

endpackage

// ==== logic/mult_top.sv ====
//##########################################################################
// top level of the streaming multiplier, plain valid/ready stream ports
//##########################################################################
`timescale 1ns/10ps

module mult_top (
   input  logic                 clk,
   input  logic                 rst_n,
   input  mult_pkg::operand_a_t a_tdata,
   input  logic                 a_tlast,
   input  logic                 a_tvalid,
   output logic                 a_tready,
   input  mult_pkg::operand_b_t b_tdata,
   input  logic                 b_tlast,
   input  logic                 b_tvalid,
   output logic                 b_tready,
   output mult_pkg::product_t   p_tdata,
   output logic                 p_tlast,
   output logic                 p_tvalid,
   input  logic                 p_tready
);

   mult u_mult (
      .clk      (clk),
      .rst_n    (rst_n),
      .a_tdata  (a_tdata),
      .a_tlast  (a_tlast),
      .a_tvalid (a_tvalid),
      .a_tready (a_tready),
      .b_tdata  (b_tdata),
      .b_tlast  (b_tlast),
      .b_tvalid (b_tvalid),
      .b_tready (b_tready),
      .p_tdata  (p_tdata),
      .p_tlast  (p_tlast),
      .p_tvalid (p_tvalid),
      .p_tready (p_tready)
   );

endmodule

// ==== logic/pipe_pkg.sv ====
//##########################################################################
// pipeline control types, one bit per stage, stage 0 nearest the input
//##########################################################################
`include "mult_config.svh"

package pipe_pkg;

   // enables and valids of the stage chain
   typedef logic [`MULT_LATENCY-1:0] stage_vec_t;

endpackage

// ==== sim/mult_checker.sv ====
//##########################################################################
// scoreboard on the top level ports, sampled on the rising clock edge
// the expected queue is flushed while reset is low
//##########################################################################
`timescale 1ns/10ps
`include "mult_config.svh"

module mult_checker (
   input logic                 clk,
   input logic                 rst_n,
   input mult_pkg::operand_a_t a_tdata,
   input logic                 a_tlast,
   input logic                 a_tvalid,
   input logic                 a_tready,
   input mult_pkg::operand_b_t b_tdata,
   input logic                 b_tvalid,
   input logic                 b_tready,
   input mult_pkg::product_t   p_tdata,
   input logic                 p_tlast,
   input logic                 p_tvalid,
   input logic                 p_tready
);

   mult_pkg::product_t exp_q[$];
   logic               last_q[$];
   int                 cyc_q[$];
   string              cur_test = "reset";
   bit                 lat_check = 1'b0;
   int                 cycle = 0;
   int                 prev_out = 0;
   int                 test_checks = 0;
   int                 test_errors = 0;
   int                 total_checks = 0;
   int                 total_errors = 0;
   int                 test_count = 0;
   logic               stalled = 1'b0;
   mult_pkg::product_t held_p;
   logic               held_last;

   // full width signed product
   function automatic mult_pkg::product_t ref_product(input mult_pkg::operand_a_t a,
                                                      input mult_pkg::operand_b_t b);
      longint pa;
      longint pb;
      pa = a;
      pb = b;
      return mult_pkg::product_t'(pa * pb);
   endfunction

   task automatic start_test(input string name, input bit lat);
      cur_test    = name;
      lat_check   = lat;
      prev_out    = 0;
      test_checks = 0;
      test_errors = 0;
   endtask

   task automatic end_test();
      $display("%s: %0d products, %0d errors", cur_test, test_checks, test_errors);
      test_count++;
   endtask

   task automatic flag(input string msg);
      $display("%s (test %s, cycle %0d)", msg, cur_test, cycle);
      test_errors++;
      total_errors++;
   endtask

   always @(posedge clk) begin
      cycle++;
      if (!rst_n) begin
         if (p_tvalid === 1'b1 || a_tready === 1'b1 || b_tready === 1'b1)
            flag("outputs still active while reset is low");
         exp_q.delete();
         last_q.delete();
         cyc_q.delete();
         stalled = 1'b0;
      end else begin
         if (a_tready !== b_tready)
            flag("a_tready and b_tready differ");
         if (a_tready && !(a_tvalid && b_tvalid))
            flag("ready raised without both operands valid");
         if (stalled && (!p_tvalid || p_tdata !== held_p || p_tlast !== held_last))
            flag("output changed while stalled");
         if (a_tready && a_tvalid && b_tvalid) begin
            exp_q.push_back(ref_product(a_tdata, b_tdata));
            last_q.push_back(a_tlast);
            cyc_q.push_back(cycle);
         end
         if (p_tvalid && p_tready) begin
            if (exp_q.size() == 0) begin
               flag("product delivered with nothing outstanding");
            end else begin
               held_p    = exp_q.pop_front();
               held_last = last_q.pop_front();
               test_checks++;
               total_checks++;
               if (p_tdata !== held_p) begin
                  $display("Fail %s: product expected %0d actual %0d", cur_test, held_p, p_tdata);
                  test_errors++;
                  total_errors++;
               end
               if (p_tlast !== held_last) begin
                  $display("Fail %s: tlast expected %0b actual %0b", cur_test, held_last, p_tlast);
                  test_errors++;
                  total_errors++;
               end
               if (lat_check && cycle - cyc_q[0] != `MULT_LATENCY) begin
                  $display("Fail %s: latency expected %0d actual %0d", cur_test,
                           `MULT_LATENCY, cycle - cyc_q[0]);
                  test_errors++;
                  total_errors++;
               end
               if (lat_check && prev_out != 0 && cycle - prev_out != 1) begin
                  $display("Fail %s: output spacing expected 1 actual %0d", cur_test,
                           cycle - prev_out);
                  test_errors++;
                  total_errors++;
               end
               prev_out = cycle;
               void'(cyc_q.pop_front());
            end
         end
         stalled   = p_tvalid && !p_tready;
         held_p    = p_tdata;
         held_last = p_tlast;
      end
   end

endmodule

// ==== sim/mult_tb.sv ====
//##########################################################################
// streams random and corner operands through the multiplier
// inputs change on the falling edge, the checker samples on the rising one
//##########################################################################
`timescale 1ns/10ps
`include "mult_config.svh"

module mult_tb;

   localparam int TOTAL_BEATS = 16 + 32 + 200 + 8 + 60 + 40;
   localparam int CYCLE_LIMIT = TOTAL_BEATS * 4 + `MULT_LATENCY + 200;

   logic clk, rst_n, rst_req;
   mult_pkg::operand_a_t a_tdata;
   mult_pkg::operand_b_t b_tdata;
   mult_pkg::product_t   p_tdata;
   logic a_tlast, a_tvalid, a_tready, b_tlast, b_tvalid, b_tready;
   logic p_tlast, p_tvalid, p_tready;
   logic [31:0] stim_seed = 32'h5627_2272;
   logic [31:0] rdy_seed  = 32'h5627_2272 ^ 32'h0000_ffff;
   bit   random_ready = 1'b0;
   int   cycles = 0;

   tb_clock u_clock (.rst_req(rst_req), .clk(clk), .rst_n(rst_n));

   mult_top DUT (
      .clk(clk), .rst_n(rst_n),
      .a_tdata(a_tdata), .a_tlast(a_tlast), .a_tvalid(a_tvalid), .a_tready(a_tready),
      .b_tdata(b_tdata), .b_tlast(b_tlast), .b_tvalid(b_tvalid), .b_tready(b_tready),
      .p_tdata(p_tdata), .p_tlast(p_tlast), .p_tvalid(p_tvalid), .p_tready(p_tready)
   );

   mult_checker chk (
      .clk(clk), .rst_n(rst_n),
      .a_tdata(a_tdata), .a_tlast(a_tlast), .a_tvalid(a_tvalid), .a_tready(a_tready),
      .b_tdata(b_tdata), .b_tvalid(b_tvalid), .b_tready(b_tready),
      .p_tdata(p_tdata), .p_tlast(p_tlast), .p_tvalid(p_tvalid), .p_tready(p_tready)
   );

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [31:0] rand_word();
      stim_seed = lcg_step(stim_seed);
      return stim_seed;
   endfunction

   always @(negedge clk) begin
      rdy_seed = lcg_step(rdy_seed);
      p_tready = random_ready ? rdy_seed[20] : 1'b1;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: run hung after %0d cycles with %0d items outstanding",
                  cycles, chk.exp_q.size());
         $display("Test failed");
         $finish;
      end
   end

   // called on a falling edge, returns on the falling edge after the transfer
   task automatic send(input mult_pkg::operand_a_t a, input mult_pkg::operand_b_t b,
                       input logic last, input bit gaps);
      logic [31:0] r;
      r = rand_word();
      while (gaps && r[17:16] == 2'b00) begin
         a_tvalid = 1'b0;
         b_tvalid = 1'b0;
         @(negedge clk);
         r = rand_word();
      end
      a_tdata  = a;
      b_tdata  = b;
      a_tlast  = last;
      b_tlast  = ~last;  // b side flag is ignored by the DUT
      a_tvalid = 1'b1;
      b_tvalid = 1'b1;
      #1;
      while (!a_tready) begin
         @(negedge clk);
         #1;
      end
      @(negedge clk);
   endtask

   task automatic send_random(input int n, input bit gaps);
      logic [31:0] ra;
      logic [31:0] rb;
      for (int i = 0; i < n; i++) begin
         ra = rand_word();
         rb = rand_word();
         send(mult_pkg::operand_a_t'(ra >> 7), mult_pkg::operand_b_t'(rb >> 9), ra[3], gaps);
      end
   endtask

   task automatic drain();
      a_tvalid = 1'b0;
      b_tvalid = 1'b0;
      while (chk.exp_q.size() != 0) @(negedge clk);
      chk.end_test();
   endtask

   initial begin
      mult_pkg::operand_a_t ca[4];
      mult_pkg::operand_b_t cb[4];
      logic [31:0] r;
      int left;
      int len;
      rst_req  = 1'b0;
      a_tdata  = '0;
      b_tdata  = '0;
      a_tlast  = 1'b0;
      b_tlast  = 1'b0;
      a_tvalid = 1'b0;
      b_tvalid = 1'b0;
      p_tready = 1'b0;
      ca = '{{1'b1, {(`MULT_WIDTH_A-1){1'b0}}}, {1'b0, {(`MULT_WIDTH_A-1){1'b1}}}, '0, '1};
      cb = '{{1'b1, {(`MULT_WIDTH_B-1){1'b0}}}, {1'b0, {(`MULT_WIDTH_B-1){1'b1}}}, '0, '1};
      @(posedge rst_n);
      @(negedge clk);

      chk.start_test("corners", 1'b0);
      foreach (ca[i]) foreach (cb[j]) send(ca[i], cb[j], j == 3, 1'b0);
      drain();

      chk.start_test("latency", 1'b1);
      send_random(32, 1'b0);
      drain();

      chk.start_test("backpressure", 1'b0);
      random_ready = 1'b1;
      send_random(200, 1'b1);
      drain();

      chk.start_test("join", 1'b0);
      for (int i = 0; i < 8; i++) begin
         r = rand_word();
         a_tdata  = mult_pkg::operand_a_t'(r >> 5);
         b_tdata  = mult_pkg::operand_b_t'(r >> 13);
         a_tvalid = r[2];  // one side arrives first
         b_tvalid = ~r[2];
         repeat (1 + r[1:0]) @(negedge clk);
         send(a_tdata, b_tdata, r[4], 1'b0);
      end
      drain();

      chk.start_test("last", 1'b0);
      left = 60;
      while (left > 0) begin
         r   = rand_word();
         len = (1 + r[10:8] > left) ? left : 1 + r[10:8];
         for (int j = 0; j < len; j++) begin
            r = rand_word();
            send(mult_pkg::operand_a_t'(r >> 7), mult_pkg::operand_b_t'(r), j == len - 1, 1'b1);
         end
         left -= len;
      end
      drain();

      chk.start_test("reset", 1'b0);
      send_random(20, 1'b1);
      rst_req  = 1'b1;  // operands stay valid across the reset
      repeat (3) @(negedge clk);
      rst_req = 1'b0;
      @(negedge clk);
      send_random(20, 1'b1);
      drain();

      $display("%0d tests, %0d products checked, %0d errors",
               chk.test_count, chk.total_checks, chk.total_errors);
      if (chk.total_errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== sim/tb_clock.sv ====
//##########################################################################
// 8 ns clock, reset low for the first 4 cycles or while rst_req is high
//##########################################################################
`timescale 1ns/10ps

module tb_clock #(
   parameter real PERIOD     = 8.0,
   parameter int  RST_CYCLES = 4
) (
   input  logic rst_req,
   output logic clk,
   output logic rst_n
);

   logic por_n;

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2.0) clk = ~clk;
   end

   initial begin
      por_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      por_n = 1'b1;  // release away from the rising edge
   end

   assign rst_n = por_n & ~rst_req;

endmodule
